//--- source/bldc_pkg.sv
//----------------------------------------
// Shared definitions of the BLDC peripheral
// Bus and counter widths
// Register byte offsets
// Hall, sector, phase and direction types
// Bus, command and hall status structs
//----------------------------------------
`default_nettype none

package bldc_pkg;

  // APB data and byte address widths
  localparam int data_width = 32;
  localparam int addr_width = 8;
  // PWM counter, duty and period
  localparam int pwm_width = 16;
  // Signed hall transition counter
  localparam int position_width = 32;

  //--------------------------------------
  // Register map
  //--------------------------------------
  localparam logic [addr_width-1:0] reg_status      = 8'h00;
  localparam logic [addr_width-1:0] reg_position    = 8'h04;
  localparam logic [addr_width-1:0] reg_control     = 8'h08;
  localparam logic [addr_width-1:0] reg_pwm_control = 8'h0C;

  // Hall bits ordered A, B, C from the top
  typedef logic [2:0] hall_t;
  // Sector 0 to 5
  typedef logic [2:0] sector_t;
  // AH BH CH on top, AL BL CL below
  typedef logic [5:0] phase_t;

  typedef enum logic [1:0] {
    DIR_NONE,
    DIR_CW,
    DIR_CCW
  } rotation_direction_t;

  //--------------------------------------
  // Packed structs
  //--------------------------------------
  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [addr_width-1:0] paddr;
    logic [data_width-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [data_width-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

  // Registered motor control
  typedef struct packed {
    logic                 enable;
    rotation_direction_t  dir;
    logic                 invert_phases;
    logic [pwm_width-1:0] pwm_duty;
    logic [pwm_width-1:0] cycle_ticks;
  } motor_cmd_t;

  // Decoded hall state
  typedef struct packed {
    hall_t                             hall;
    sector_t                           sector;
    rotation_direction_t               detected_dir;
    logic                              hall_error;
    logic signed [position_width-1:0]  position;
  } hall_status_t;

endpackage

`default_nettype wire

//--- source/hall_decoder.sv
//----------------------------------------
// Hall input synchroniser
// Sector decode and hall error flag
// Rotation direction and position counter
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module hall_decoder
  import bldc_pkg::*;
(
  input  logic         pclk,
  input  logic         preset_n,
  input  hall_t        hall_values,
  output hall_status_t status
);

  // Two flop synchroniser stages
  hall_t   hall_meta_;
  hall_t   hall_sync_;
  // Sector of the synchronised code
  sector_t sector_new_;
  logic    code_valid_;
  // Neighbours of the held sector
  sector_t sector_next_;
  sector_t sector_prev_;

  always_ff @(posedge pclk)
  begin
    if (!preset_n)
    begin
      hall_meta_ <= '0;
      hall_sync_ <= '0;
    end
    else
    begin
      hall_meta_ <= hall_values;
      hall_sync_ <= hall_meta_;
    end
  end

  //--------------------------------------
  // Code to sector
  //--------------------------------------
  always_comb
  begin
    code_valid_ = 1'b1;
    sector_new_ = status.sector;
    case (hall_sync_)
      3'b101: sector_new_ = sector_t'(0);
      3'b100: sector_new_ = sector_t'(1);
      3'b110: sector_new_ = sector_t'(2);
      3'b010: sector_new_ = sector_t'(3);
      3'b011: sector_new_ = sector_t'(4);
      3'b001: sector_new_ = sector_t'(5);
      // 000 and 111 are not hall states
      default: code_valid_ = 1'b0;
    endcase
    // Sector wraps modulo 6
    sector_next_ = (status.sector == sector_t'(5)) ? '0 : status.sector + sector_t'(1);
    sector_prev_ = (status.sector == '0) ? sector_t'(5) : status.sector - sector_t'(1);
  end

  // Decode register
  always_ff @(posedge pclk)
  begin
    if (!preset_n)
      status <= '0;
    else
    begin
      status.hall <= hall_sync_;
      if (!code_valid_)
        // Sector holds while the code is bad
        status.hall_error <= 1'b1;
      else
      begin
        status.hall_error <= 1'b0;
        status.sector     <= sector_new_;
        // One step forward
        if (sector_new_ == sector_next_)
        begin
          status.detected_dir <= DIR_CW;
          status.position     <= status.position + position_width'(1);
        end
        // One step back
        else if (sector_new_ == sector_prev_)
        begin
          status.detected_dir <= DIR_CCW;
          status.position     <= status.position - position_width'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/pwm_generator.sv
//----------------------------------------
// PWM period counter
// Duty comparison to the PWM level
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pwm_generator
  import bldc_pkg::*;
(
  input  logic       pclk,
  input  logic       preset_n,
  input  motor_cmd_t cmd,
  output logic       pwm_level
);

  // Position inside the PWM period
  logic [pwm_width-1:0] count_;

  always_ff @(posedge pclk)
  begin
    if (!preset_n)
    begin
      count_    <= '0;
      pwm_level <= 1'b0;
    end
    // Zero period parks the counter
    else if (cmd.cycle_ticks == '0)
    begin
      count_    <= '0;
      pwm_level <= 1'b0;
    end
    else
    begin
      // High for the first pwm_duty counts
      pwm_level <= (count_ < cmd.pwm_duty);
      // Wrap at the last tick, also after a shorter period is written
      if (count_ >= cmd.cycle_ticks - pwm_width'(1))
        count_ <= '0;
      else
        count_ <= count_ + pwm_width'(1);
    end
  end

endmodule

`default_nettype wire

//--- source/commutation_driver.sv
//----------------------------------------
// Six-step commutation table
// Direction offset and phase inversion
// Fault gating and high-side PWM chop
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module commutation_driver
  import bldc_pkg::*;
(
  input  logic         pclk,
  input  logic         preset_n,
  input  motor_cmd_t   cmd,
  input  hall_status_t hall,
  input  logic         pwm_level,
  input  logic         fault_n,
  input  logic         overcurrent_n,
  output phase_t       phase_enable,
  output phase_t       pwm_out,
  output logic         gate_enable
);

  sector_t table_sector_;
  phase_t  pattern_;
  phase_t  phase_next_;
  logic    fault_active_;
  logic    run_;

  // Clockwise pattern per sector
  function automatic phase_t cw_pattern(input sector_t sector);
    case (sector)
      3'd0:    return 6'b100_010;
      3'd1:    return 6'b100_001;
      3'd2:    return 6'b010_001;
      3'd3:    return 6'b010_100;
      3'd4:    return 6'b001_100;
      3'd5:    return 6'b001_010;
      default: return '0;
    endcase
  endfunction

  always_comb
  begin
    fault_active_ = !fault_n || !overcurrent_n;
    // CCW uses the entry three sectors on
    table_sector_ = hall.sector;
    if (cmd.dir == DIR_CCW)
      table_sector_ = (hall.sector >= sector_t'(3)) ? hall.sector - sector_t'(3)
                                                   : hall.sector + sector_t'(3);
    pattern_ = cw_pattern(table_sector_);
    // Swap high and low halves
    if (cmd.invert_phases)
      pattern_ = {pattern_[2:0], pattern_[5:3]};
    run_ = cmd.enable && (cmd.dir == DIR_CW || cmd.dir == DIR_CCW) && !hall.hall_error &&
           !fault_active_;
    phase_next_ = run_ ? pattern_ : '0;
  end

  // Registered gate outputs
  always_ff @(posedge pclk)
  begin
    if (!preset_n)
    begin
      phase_enable <= '0;
      pwm_out      <= '0;
      gate_enable  <= 1'b0;
    end
    else
    begin
      phase_enable <= phase_next_;
      // Chop high sides only
      pwm_out      <= {phase_next_[5:3] & {3{pwm_level}}, phase_next_[2:0]};
      gate_enable  <= cmd.enable && !fault_active_;
    end
  end

endmodule

`default_nettype wire

//--- source/bldc_apb_regs.sv
//----------------------------------------
// APB slave with one wait state
// Control and PWM control registers
// Status and position readback
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bldc_apb_regs
  import bldc_pkg::*;
(
  input  logic         pclk,
  input  logic         preset_n,
  input  apb_req_t     req,
  output apb_rsp_t     rsp,
  output motor_cmd_t   cmd,
  input  hall_status_t hall,
  input  phase_t       phase_enable,
  input  logic         fault_n,
  input  logic         overcurrent_n
);

  typedef enum logic [1:0] {
    idle_state,
    write_access,
    read_access
  } apb_state_t;

  apb_state_t            apb_state_;
  // Address decode results
  logic                  read_ok_;
  logic                  write_ok_;
  logic [data_width-1:0] read_data_;

  //--------------------------------------
  // Address decode and read mux
  //--------------------------------------
  always_comb
  begin
    read_ok_   = 1'b0;
    write_ok_  = 1'b0;
    read_data_ = '0;
    case (req.paddr)
      reg_status:
      begin
        read_ok_   = 1'b1;
        read_data_ = {{(data_width - 17){1'b0}}, ~overcurrent_n, ~fault_n, hall.hall_error,
                      phase_enable, hall.detected_dir, hall.sector, hall.hall};
      end
      reg_position:
      begin
        read_ok_   = 1'b1;
        read_data_ = hall.position;
      end
      reg_control:
      begin
        read_ok_   = 1'b1;
        write_ok_  = 1'b1;
        read_data_ = {{(data_width - 4){1'b0}}, cmd.invert_phases, cmd.dir, cmd.enable};
      end
      reg_pwm_control:
      begin
        read_ok_   = 1'b1;
        write_ok_  = 1'b1;
        read_data_ = {cmd.cycle_ticks, cmd.pwm_duty};
      end
      // Anything else answers with pslverr
      default: read_data_ = '0;
    endcase
  end

  //--------------------------------------
  // Transfer FSM
  //--------------------------------------
  always_ff @(posedge pclk)
  begin
    if (!preset_n)
    begin
      apb_state_ <= idle_state;
      rsp        <= '0;
      rsp.pready <= 1'b1;
      cmd        <= '0;
    end
    else
    begin
      case (apb_state_)
        idle_state:
        begin
          rsp.prdata  <= '0;
          rsp.pslverr <= 1'b0;
          // Setup cycle opens the wait state
          if (req.psel && !req.penable)
          begin
            rsp.pready <= 1'b0;
            apb_state_ <= req.pwrite ? write_access : read_access;
          end
          // Closing edge of a completed write
          else if (req.psel && req.penable && req.pwrite && write_ok_)
          begin
            if (req.paddr == reg_control)
            begin
              cmd.enable        <= req.pwdata[0];
              // Disabled motor keeps no direction
              cmd.dir           <= req.pwdata[0] ? rotation_direction_t'(req.pwdata[2:1])
                                                 : DIR_NONE;
              cmd.invert_phases <= req.pwdata[3];
            end
            else
            begin
              cmd.pwm_duty    <= req.pwdata[pwm_width-1:0];
              cmd.cycle_ticks <= req.pwdata[2*pwm_width-1:pwm_width];
            end
          end
        end
        // End of the wait state
        write_access:
        begin
          rsp.pslverr <= !write_ok_;
          rsp.pready  <= 1'b1;
          apb_state_  <= idle_state;
        end
        read_access:
        begin
          rsp.prdata  <= read_data_;
          rsp.pslverr <= !read_ok_;
          rsp.pready  <= 1'b1;
          apb_state_  <= idle_state;
        end
        default: apb_state_ <= idle_state;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/bldc_peripheral.sv
//----------------------------------------
// BLDC peripheral top level
// Hall decode, PWM, commutation, APB regs
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bldc_peripheral
  import bldc_pkg::*;
(
  input  logic     pclk,
  input  logic     preset_n,
  input  apb_req_t req,
  output apb_rsp_t rsp,
  input  hall_t    hall_values,
  input  logic     fault_n,
  input  logic     overcurrent_n,
  output phase_t   phase_enable,
  output phase_t   pwm_out,
  output logic     gate_enable
);

  // Internal buses
  hall_status_t hall_status_;
  motor_cmd_t   cmd_;
  logic         pwm_level_;

  // Hall decode
  hall_decoder i_hall_decoder (
    .pclk        (pclk),
    .preset_n    (preset_n),
    .hall_values (hall_values),
    .status      (hall_status_)
  );

  // PWM level from duty and period
  pwm_generator i_pwm_generator (
    .pclk      (pclk),
    .preset_n  (preset_n),
    .cmd       (cmd_),
    .pwm_level (pwm_level_)
  );

  // Gate drive
  commutation_driver i_commutation_driver (
    .pclk          (pclk),
    .preset_n      (preset_n),
    .cmd           (cmd_),
    .hall          (hall_status_),
    .pwm_level     (pwm_level_),
    .fault_n       (fault_n),
    .overcurrent_n (overcurrent_n),
    .phase_enable  (phase_enable),
    .pwm_out       (pwm_out),
    .gate_enable   (gate_enable)
  );

  // Register block
  bldc_apb_regs i_bldc_apb_regs (
    .pclk          (pclk),
    .preset_n      (preset_n),
    .req           (req),
    .rsp           (rsp),
    .cmd           (cmd_),
    .hall          (hall_status_),
    .phase_enable  (phase_enable),
    .fault_n       (fault_n),
    .overcurrent_n (overcurrent_n)
  );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
//----------------------------------------
// Testbench clock, 4 ns period
// Synchronous reset for three cycles
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic pclk,
  output logic preset_n
);

  // Half period of 2 ns
  initial
  begin
    pclk = 1'b0;
    forever #2 pclk = ~pclk;
  end

  // Released on a falling edge after three rising edges
  initial
  begin
    preset_n = 1'b0;
    repeat (3) @(posedge pclk);
    @(negedge pclk);
    preset_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- verif/tb_bldc_peripheral.sv
//----------------------------------------
// Testbench of the BLDC peripheral
// APB transfer tasks and compare tasks
// Reference model building a stimulus table
// Register, bus error, hall, commutation,
// fault and PWM duty checks with a timeout
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_bldc_peripheral
  import bldc_pkg::*;
();

  // One table step with its expected results
  typedef struct packed {
    hall_t                 hall;
    logic                  fault_n;
    logic                  overcurrent_n;
    logic [3:0]            control;
    logic [data_width-1:0] pwm;
    logic [data_width-1:0] exp_status;
    logic [data_width-1:0] exp_position;
    phase_t                exp_phase;
    rotation_direction_t   exp_dir;
    logic                  exp_gate;
  } row_t;

  logic     pclk;
  logic     preset_n;
  apb_req_t req;
  apb_rsp_t rsp;
  hall_t    hall_values;
  logic     fault_n;
  logic     overcurrent_n;
  phase_t   phase_enable;
  phase_t   pwm_out;
  logic     gate_enable;

  row_t                  rows[$];
  string                 row_names[$];
  // Reference model state
  sector_t               model_sector;
  rotation_direction_t   model_dir;
  logic [data_width-1:0] model_position;

  int     mismatch_count = 0;
  int     bus_error_count = 0;
  int     cycle_count = 0;
  int     cycle_limit = 4 * 256;
  integer seed;

  tb_clock_gen i_tb_clock_gen (
    .pclk     (pclk),
    .preset_n (preset_n)
  );

  bldc_peripheral i_bldc_peripheral (
    .pclk          (pclk),
    .preset_n      (preset_n),
    .req           (req),
    .rsp           (rsp),
    .hall_values   (hall_values),
    .fault_n       (fault_n),
    .overcurrent_n (overcurrent_n),
    .phase_enable  (phase_enable),
    .pwm_out       (pwm_out),
    .gate_enable   (gate_enable)
  );

  // Run limit
  always @(posedge pclk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit)
    begin
      $display("Timeout: run stopped after %0d cycles", cycle_count);
      $display("Simulation FAILED");
      $finish;
    end
  end

  //--------------------------------------
  // Compare tasks
  //--------------------------------------
  task automatic compare_word(input string name, input logic [data_width-1:0] expected,
                              input logic [data_width-1:0] actual);
    if (actual !== expected)
    begin
      $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic compare_phase(input string name, input phase_t expected, input phase_t actual);
    if (actual !== expected)
    begin
      $display("MISMATCH %s expected %06b actual %06b", name, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic compare_dir(input string name, input rotation_direction_t expected,
                             input rotation_direction_t actual);
    if (actual !== expected)
    begin
      $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
      mismatch_count++;
    end
  endtask

  // Slave error response against what the access should give
  task automatic check_slave_error(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
      if (expected)
        $display("Bus error: %s completed without pslverr", name);
      else
        $display("Bus error: %s completed with an unexpected pslverr", name);
      bus_error_count++;
    end
  endtask

  //--------------------------------------
  // APB master
  //--------------------------------------
  task automatic bus_transfer(input logic write, input logic [addr_width-1:0] addr,
                              input logic [data_width-1:0] wdata,
                              output logic [data_width-1:0] rdata, output logic slverr);
    int waits;
    // Setup cycle
    @(negedge pclk);
    req.psel    = 1'b1;
    req.penable = 1'b0;
    req.pwrite  = write;
    req.paddr   = addr;
    req.pwdata  = wdata;
    @(negedge pclk);
    req.penable = 1'b1;
    // First access cycle sampled too, pready low there
    waits = 0;
    while (!rsp.pready && waits < 8)
    begin
      @(negedge pclk);
      waits++;
    end
    if (!rsp.pready)
    begin
      $display("Bus error: no pready within 8 cycles at address 0x%02h", addr);
      bus_error_count++;
    end
    else if (waits != 1)
    begin
      $display("Bus error: transfer at address 0x%02h took %0d wait states instead of one",
               addr, waits);
      bus_error_count++;
    end
    rdata  = rsp.prdata;
    slverr = rsp.pslverr;
    // Hold through the closing edge
    @(negedge pclk);
    req = '0;
  endtask

  task automatic apb_write(input logic [addr_width-1:0] addr, input logic [data_width-1:0] data,
                           output logic slverr);
    logic [data_width-1:0] unused;
    bus_transfer(1'b1, addr, data, unused, slverr);
  endtask

  task automatic apb_read(input logic [addr_width-1:0] addr, output logic [data_width-1:0] data,
                          output logic slverr);
    bus_transfer(1'b0, addr, '0, data, slverr);
  endtask

  //--------------------------------------
  // Reference model
  //--------------------------------------
  // Hall code of each sector
  function automatic hall_t hall_code(input int sector);
    case (sector)
      0:       return 3'b101;
      1:       return 3'b100;
      2:       return 3'b110;
      3:       return 3'b010;
      4:       return 3'b011;
      default: return 3'b001;
    endcase
  endfunction

  // Valid flag on top, sector below
  function automatic logic [3:0] decode_hall(input hall_t code);
    logic [3:0] result;
    result = 4'b0000;
    for (int s = 0; s < 6; s++)
      if (hall_code(s) == code)
        result = {1'b1, sector_t'(s)};
    return result;
  endfunction

  // Leg index 0 is A, 1 is B, 2 is C
  function automatic phase_t expected_phase(input sector_t sector, input rotation_direction_t dir,
                                            input logic invert, input logic run);
    int     table_sector;
    int     high_leg;
    int     low_leg;
    phase_t pattern;
    pattern = '0;
    if (!run || !(dir == DIR_CW || dir == DIR_CCW))
      return pattern;
    table_sector = (dir == DIR_CCW) ? (int'(sector) + 3) % 6 : int'(sector);
    // High side A A B B C C, low side B C C A A B
    high_leg = table_sector / 2;
    low_leg  = ((table_sector + 1) / 2 + 1) % 3;
    pattern[5 - high_leg] = 1'b1;
    pattern[2 - low_leg]  = 1'b1;
    if (invert)
      pattern = {pattern[2:0], pattern[5:3]};
    return pattern;
  endfunction

  // Control readback with dir cleared when disabled
  function automatic logic [data_width-1:0] expected_control(input logic [data_width-1:0] word);
    return {{(data_width - 4){1'b0}}, word[3], word[0] ? word[2:1] : 2'b00, word[0]};
  endfunction

  // Steps the model and appends one row
  task automatic add_row(input string name, input hall_t hall, input logic fault_level,
                         input logic overcurrent_level, input logic [3:0] control);
    logic [3:0]          decoded;
    logic                error;
    rotation_direction_t cmd_dir;
    row_t                row;
    decoded = decode_hall(hall);
    error   = !decoded[3];
    if (!error)
    begin
      if (int'(decoded[2:0]) == (int'(model_sector) + 1) % 6)
      begin
        model_dir      = DIR_CW;
        model_position = model_position + 1;
      end
      else if (int'(decoded[2:0]) == (int'(model_sector) + 5) % 6)
      begin
        model_dir      = DIR_CCW;
        model_position = model_position - 1;
      end
      model_sector = decoded[2:0];
    end
    cmd_dir = control[0] ? rotation_direction_t'(control[2:1]) : DIR_NONE;
    row.hall          = hall;
    row.fault_n       = fault_level;
    row.overcurrent_n = overcurrent_level;
    row.control       = control;
    row.pwm           = {16'd100, 16'd30};
    row.exp_phase     = expected_phase(model_sector, cmd_dir, control[3],
                                       control[0] && !error && fault_level && overcurrent_level);
    row.exp_dir       = model_dir;
    row.exp_position  = model_position;
    row.exp_gate      = control[0] && fault_level && overcurrent_level;
    row.exp_status    = {15'b0, !overcurrent_level, !fault_level, error, row.exp_phase,
                         model_dir, model_sector, hall};
    rows.push_back(row);
    row_names.push_back(name);
  endtask

  task automatic build_table();
    model_sector   = '0;
    model_dir      = DIR_NONE;
    model_position = '0;
    add_row("start_sector0", hall_code(0), 1'b1, 1'b1, 4'h3);
    // Two forward laps, the second one inverted
    for (int lap = 0; lap < 2; lap++)
      for (int step = 1; step <= 6; step++)
        add_row($sformatf("cw_lap%0d_sector%0d", lap, step % 6), hall_code(step % 6),
                1'b1, 1'b1, lap ? 4'hB : 4'h3);
    // Two backward laps
    for (int lap = 0; lap < 2; lap++)
      for (int step = 1; step <= 6; step++)
        add_row($sformatf("ccw_lap%0d_sector%0d", lap, (6 - step) % 6),
                hall_code((6 - step) % 6), 1'b1, 1'b1, lap ? 4'hD : 4'h5);
    add_row("hall_code_000", 3'b000, 1'b1, 1'b1, 4'h3);
    add_row("hall_code_111", 3'b111, 1'b1, 1'b1, 4'h3);
    add_row("hall_recover", hall_code(1), 1'b1, 1'b1, 4'h3);
    // Enable low with CW bits written
    add_row("disabled", hall_code(0), 1'b1, 1'b1, 4'h2);
    add_row("fault", hall_code(0), 1'b0, 1'b1, 4'h3);
    add_row("overcurrent", hall_code(0), 1'b1, 1'b0, 4'h3);
    add_row("both_faults", hall_code(0), 1'b0, 1'b0, 4'h3);
  endtask

  //--------------------------------------
  // Row and PWM steps
  //--------------------------------------
  task automatic apply_row(input int index);
    row_t                  row;
    string                 name;
    logic [data_width-1:0] data;
    logic                  err;
    row  = rows[index];
    name = row_names[index];
    @(negedge pclk);
    hall_values   = row.hall;
    fault_n       = row.fault_n;
    overcurrent_n = row.overcurrent_n;
    apb_write(reg_control, {28'b0, row.control}, err);
    check_slave_error({name, " control write"}, err, 1'b0);
    apb_write(reg_pwm_control, row.pwm, err);
    check_slave_error({name, " pwm write"}, err, 1'b0);
    // Sync, decode and driver registers settle
    repeat (6) @(negedge pclk);
    apb_read(reg_status, data, err);
    check_slave_error({name, " status read"}, err, 1'b0);
    compare_word({name, " status"}, row.exp_status, data);
    compare_dir({name, " detected_dir"}, row.exp_dir, rotation_direction_t'(data[7:6]));
    apb_read(reg_position, data, err);
    check_slave_error({name, " position read"}, err, 1'b0);
    compare_word({name, " position"}, row.exp_position, data);
    compare_phase({name, " phase_enable"}, row.exp_phase, phase_enable);
    compare_phase({name, " pwm_out low side"}, row.exp_phase & 6'b000_111,
                  pwm_out & 6'b000_111);
    compare_word({name, " gate_enable"}, {31'b0, row.exp_gate}, {31'b0, gate_enable});
  endtask

  // Cycles with the energized high side on
  task automatic count_high_side(input phase_t energized, input int cycles, output int count);
    count = 0;
    repeat (cycles)
    begin
      @(negedge pclk);
      if ((pwm_out[5:3] & energized[5:3]) != 3'b000)
        count++;
    end
  endtask

  //--------------------------------------
  // Main sequence
  //--------------------------------------
  initial
  begin
    logic [data_width-1:0] data;
    logic                  err;
    logic [data_width-1:0] ctrl_word;
    logic [data_width-1:0] pwm_word;
    int                    high_count;
    phase_t                energized;
    seed          = 94915;
    req           = '0;
    hall_values   = 3'b101;
    fault_n       = 1'b1;
    overcurrent_n = 1'b1;
    build_table();
    cycle_limit = rows.size() * 40 + 4 * 256;
    @(posedge preset_n);

    // Register readback
    apb_write(reg_control, 32'h5, err);
    check_slave_error("control write", err, 1'b0);
    apb_read(reg_control, data, err);
    check_slave_error("control read", err, 1'b0);
    compare_word("control readback", 32'h5, data);
    apb_write(reg_control, 32'hE, err);
    apb_read(reg_control, data, err);
    compare_word("control disabled dir", 32'h8, data);
    apb_write(reg_pwm_control, 32'h0064_001E, err);
    check_slave_error("pwm write", err, 1'b0);
    apb_read(reg_pwm_control, data, err);
    check_slave_error("pwm read", err, 1'b0);
    compare_word("pwm readback", 32'h0064_001E, data);
    // Random readback step
    ctrl_word = $random(seed);
    pwm_word  = $random(seed);
    apb_write(reg_control, ctrl_word, err);
    apb_write(reg_pwm_control, pwm_word, err);
    apb_read(reg_control, data, err);
    compare_word("random control readback", expected_control(ctrl_word), data);
    apb_read(reg_pwm_control, data, err);
    compare_word("random pwm readback", pwm_word, data);

    // Bus errors
    apb_write(reg_status, 32'hFFFF_FFFF, err);
    check_slave_error("status write", err, 1'b1);
    apb_write(reg_position, 32'h1234_5678, err);
    check_slave_error("position write", err, 1'b1);
    apb_write(8'h10, 32'h1, err);
    check_slave_error("unmapped write", err, 1'b1);
    apb_read(8'h10, data, err);
    check_slave_error("unmapped read", err, 1'b1);

    for (int i = 0; i < rows.size(); i++)
      apply_row(i);

    // PWM duty in sector 0, CW
    @(negedge pclk);
    hall_values   = hall_code(0);
    fault_n       = 1'b1;
    overcurrent_n = 1'b1;
    apb_write(reg_control, 32'h3, err);
    apb_write(reg_pwm_control, {16'd100, 16'd30}, err);
    energized = expected_phase(sector_t'(0), DIR_CW, 1'b0, 1'b1);
    repeat (8) @(negedge pclk);
    count_high_side(energized, 100, high_count);
    compare_word("pwm duty 30", 32'd30, high_count);
    repeat (37) @(negedge pclk);
    count_high_side(energized, 100, high_count);
    compare_word("pwm duty 30 shifted window", 32'd30, high_count);
    apb_write(reg_pwm_control, {16'd100, 16'd0}, err);
    repeat (4) @(negedge pclk);
    count_high_side(energized, 100, high_count);
    compare_word("pwm duty 0", 32'd0, high_count);

    $display("Errors: %0d mismatches, %0d bus errors", mismatch_count, bus_error_count);
    if (mismatch_count == 0 && bus_error_count == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
source/bldc_pkg.sv
source/hall_decoder.sv
source/pwm_generator.sv
source/commutation_driver.sv
source/bldc_apb_regs.sv
source/bldc_peripheral.sv
verif/tb_clock_gen.sv
verif/tb_bldc_peripheral.sv

//--- Bender.yml
package:
  name: bldc_peripheral

sources:
  - source/bldc_pkg.sv
  - source/hall_decoder.sv
  - source/pwm_generator.sv
  - source/commutation_driver.sv
  - source/bldc_apb_regs.sv
  - source/bldc_peripheral.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_bldc_peripheral.sv
